// File: audPkg.sv
//**********************************************************
// bus and response enums, control word, buffer write record,
// sample rate reload table and shared widths
//**********************************************************
package audPkg;

	// widest buffer index, for 2048 words per bank
	localparam int bufIdxMaxW = 11;

	// width of the sample rate divider
	localparam int rateW = 14;

	// address bits 27:16 of the device
	localparam logic [11:0] devWindow = 12'h009;

	// bit 4 marks a store, bit 3 a load
	typedef enum logic [4:0]
	{
		opmNone    = 5'h00,
		opmLoad32  = 5'h0A,
		opmStore32 = 5'h12
	} busOpm;

	typedef enum logic [1:0]
	{
		respReady = 2'b00,
		respOk    = 2'b01
	} busResp;

	typedef struct packed
	{
		logic [23:0] reserved;
		logic [3:0]  rateSel;
		logic        outEnable;
		logic        stereo;
		logic        use16b;
		logic        useCompand;
	} audCtrl;

	typedef struct packed
	{
		logic [31:0] addr;
		logic [31:0] data;
		busOpm       opm;
	} busReq;

	// index is sized for the largest buffer, upper bits zero when smaller
	typedef struct packed
	{
		logic                  strobe;
		logic                  bank;
		logic [bufIdxMaxW-1:0] index;
		logic [31:0]           word;
	} bufWrite;

	// divider reloads per rate code, in clock cycles minus one
	localparam logic [rateW-1:0] rateReload [16] = '{
		14'd12500, 14'd9070, 14'd6250, 14'd4535,
		14'd3125,  14'd2268, 14'd1562, 14'd1134,
		14'd781,   14'd2083, 14'd781,  14'd1042,
		14'd781,   14'd781,  14'd781,  14'd781
	};

	localparam logic [rateW-1:0] rateReloadMax = 14'd12500;

endpackage

// File: audBusRegs.sv
//**********************************************************
// bus request register, window decode, control register,
// buffer write strobe and registered response
//**********************************************************
`timescale 1ns/1ps

module audBusRegs #(
	parameter int bufWords = 1024
) (
	input  logic             clock,
	input  logic             arstN,
	input  audPkg::busReq    busIn,
	output logic [31:0]      busOutData,
	output audPkg::busResp   busOK,
	output audPkg::audCtrl   ctrl,
	output audPkg::bufWrite  bufWr
);

	localparam int bufIdxW = $clog2(bufWords);

	audPkg::busReq reqQ;
	logic          winHit;
	logic          accessHit;
	logic          storeHit;
	logic          ctrlWr;
	logic          bufHit;

	// request is taken every cycle, no handshake
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			reqQ <= '0;
		else
			reqQ <= busIn;
	end

	always_comb
	begin
		winHit    = (reqQ.addr[27:16] == audPkg::devWindow);
		accessHit = winHit && (reqQ.opm[4] || reqQ.opm[3]);
		storeHit  = winHit && reqQ.opm[4];
		// control page F, first word only
		ctrlWr    = storeHit && (reqQ.addr[15:12] == 4'hF) && (reqQ.addr[11:2] == '0);
		bufHit    = storeHit && (reqQ.addr[15:14] == 2'b00);
	end

	// bank from bit 2, word index from the bits above
	always_comb
	begin
		bufWr                      = '0;
		bufWr.strobe               = bufHit;
		bufWr.bank                 = reqQ.addr[2];
		bufWr.index[bufIdxW-1:0]   = reqQ.addr[3 +: bufIdxW];
		bufWr.word                 = reqQ.data;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			ctrl <= '0;
		else if (ctrlWr)
			ctrl <= audPkg::audCtrl'(reqQ.data);
	end

	// response lands two cycles after the request
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			busOK <= audPkg::respReady;
		else if (accessHit)
			busOK <= audPkg::respOk;
		else
			busOK <= audPkg::respReady;
	end

	// reads are not supported
	assign busOutData = 32'h0;

	// control page and buffer range must never overlap
	assert property (@(posedge clock) disable iff (!arstN)
		!(ctrlWr && bufWr.strobe))
	else $error("control and buffer write in the same cycle");

endmodule

// File: audSampleBuf.sv
//**********************************************************
// two-bank sample RAM, word writes and 64-bit block reads
//**********************************************************
`timescale 1ns/1ps

module audSampleBuf #(
	parameter int bufWords = 1024
) (
	input  logic                          clock,
	input  audPkg::bufWrite               bufWr,
	input  logic [$clog2(bufWords)-1:0]   rdIdx,
	output logic [63:0]                   block
);

	localparam int bufIdxW = $clog2(bufWords);

	// bank 0 holds the low word of each block
	logic [31:0] mem [2][bufWords];

	always_ff @(posedge clock)
	begin
		if (bufWr.strobe)
			mem[bufWr.bank][bufWr.index[bufIdxW-1:0]] <= bufWr.word;
	end

	// both banks read at once
	always_ff @(posedge clock)
	begin
		block <= {mem[1][rdIdx], mem[0][rdIdx]};
	end

endmodule

// File: audSampleClock.sv
//**********************************************************
// sample rate divider and sample position counter
//**********************************************************
`timescale 1ns/1ps

module audSampleClock #(
	parameter int bufWords = 1024
) (
	input  logic                          clock,
	input  logic                          arstN,
	input  audPkg::audCtrl                ctrl,
	output logic [$clog2(bufWords)+2:0]   sampPos
);

	logic [audPkg::rateW-1:0] divCnt;
	logic [audPkg::rateW-1:0] divRst;
	logic                     divZero;

	assign divZero = (divCnt == '0);

	// reload follows the rate code with one cycle of lag
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			divRst <= '0;
		else
			divRst <= audPkg::rateReload[ctrl.rateSel];
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			divCnt  <= '0;
			sampPos <= '0;
		end
		else if (divZero)
		begin
			divCnt  <= divRst;
			sampPos <= sampPos + 1'b1;
		end
		else
		begin
			divCnt <= divCnt - 1'b1;
		end
	end

	// a count above every table entry means a corrupted reload
	assert property (@(posedge clock) disable iff (!arstN)
		divCnt <= audPkg::rateReloadMax)
	else $error("sample divider above largest reload");

endmodule

// File: audSampleDecode.sv
//**********************************************************
// lane select, companded expansion, 16-bit level with aux
//**********************************************************
`timescale 1ns/1ps

module audSampleDecode #(
	parameter int bufWords = 1024
) (
	input  logic                          clock,
	input  logic                          arstN,
	input  audPkg::audCtrl                ctrl,
	input  logic [$clog2(bufWords)+2:0]   sampPos,
	input  logic [63:0]                   block,
	input  logic [7:0]                    auxPcmL,
	input  logic [7:0]                    auxPcmR,
	input  logic                          timerNoise,
	output logic [15:0]                   levelL,
	output logic [15:0]                   levelR
);

	logic [7:0]  samp8b;
	logic [15:0] samp16b;
	logic [10:0] expand;
	logic [11:0] compand12;
	logic [11:0] samp12;
	logic [15:0] base;
	logic [15:0] nextL;
	logic [15:0] nextR;

	// byte and halfword lanes, both taken every cycle
	always_ff @(posedge clock)
	begin
		samp8b  <= block[sampPos[2:0]*8 +: 8];
		samp16b <= block[sampPos[1:0]*16 +: 16];
	end

	// sign, 3-bit exponent, 4-bit mantissa
	always_comb
	begin
		unique case (samp8b[6:4])
			3'd0: expand = {7'h00, samp8b[3:0]};
			3'd1: expand = {7'h01, samp8b[3:0]};
			3'd2: expand = {6'h01, samp8b[3:0], samp8b[3]};
			3'd3: expand = {5'h01, samp8b[3:0], samp8b[3:2]};
			3'd4: expand = {4'h1, samp8b[3:0], samp8b[3:1]};
			3'd5: expand = {3'h1, samp8b[3:0], samp8b[3:0]};
			3'd6: expand = {2'h1, samp8b[3:0], samp8b[3:0], 1'b0};
			default: expand = {1'b1, samp8b[3:0], samp8b[3:0], 2'b00};
		endcase

		// negative samples mirror around the midpoint
		if (samp8b[7])
			compand12 = {1'b1, expand};
		else
			compand12 = {1'b0, ~expand};
	end

	always_comb
	begin
		if (ctrl.use16b)
			samp12 = {samp16b[15] ^ ctrl.useCompand, samp16b[14:4]};
		else if (ctrl.useCompand)
			samp12 = compand12;
		else
			samp12 = {samp8b, 4'h0};

		// replicate top bits to reach full scale
		base  = {samp12, samp12[11:8]};
		nextL = base + {auxPcmL, 7'h00, timerNoise};
		nextR = base + {auxPcmR, 7'h00, timerNoise};
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			levelL <= '0;
			levelR <= '0;
		end
		else
		begin
			levelL <= nextL;
			levelR <= nextR;
		end
	end

endmodule

// File: audPwmDac.sv
//**********************************************************
// delta-sigma accumulators and gated PWM outputs
//**********************************************************
`timescale 1ns/1ps

module audPwmDac (
	input  logic            clock,
	input  logic            arstN,
	input  audPkg::audCtrl  ctrl,
	input  logic [15:0]     levelL,
	input  logic [15:0]     levelR,
	output logic [1:0]      pwmOut
);

	logic [15:0] level   [2];
	logic [15:0] acc     [2];
	logic [15:0] accNext [2];
	logic [1:0]  carry;

	// channel 0 left, channel 1 right
	assign level[0] = levelL;
	assign level[1] = levelR;

	always_comb
	begin
		for (int ch = 0; ch < 2; ch++)
			{carry[ch], accNext[ch]} = {1'b0, acc[ch]} + {1'b0, level[ch]};
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			acc[0] <= '0;
			acc[1] <= '0;
		end
		else
		begin
			acc[0] <= accNext[0];
			acc[1] <= accNext[1];
		end
	end

	// idle output sits high
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			pwmOut <= 2'b11;
		else if (ctrl.outEnable)
			pwmOut <= carry;
		else
			pwmOut <= 2'b11;
	end

endmodule

// File: audPcmTop.sv
//**********************************************************
// PCM sound device top level
//**********************************************************
`timescale 1ns/1ps

module audPcmTop #(
	parameter int bufWords = 1024
) (
	input  logic            clock,
	input  logic            arstN,
	input  audPkg::busReq   busIn,
	output logic [31:0]     busOutData,
	output audPkg::busResp  busOK,
	input  logic [7:0]      auxPcmL,
	input  logic [7:0]      auxPcmR,
	input  logic            timerNoise,
	output logic [1:0]      pwmOut
);

	localparam int bufIdxW = $clog2(bufWords);

	audPkg::audCtrl        ctrl;
	audPkg::bufWrite       bufWr;
	logic [bufIdxW+2:0]    sampPos;
	logic [bufIdxW-1:0]    rdIdx;
	logic [63:0]           block;
	logic [15:0]           levelL;
	logic [15:0]           levelR;

	// four halfwords or eight bytes per block
	assign rdIdx = ctrl.use16b ? sampPos[bufIdxW+1:2] : sampPos[bufIdxW+2:3];

	audBusRegs #(
		.bufWords (bufWords)
	) i_audBusRegs (
		.clock      (clock),
		.arstN      (arstN),
		.busIn      (busIn),
		.busOutData (busOutData),
		.busOK      (busOK),
		.ctrl       (ctrl),
		.bufWr      (bufWr)
	);

	audSampleBuf #(
		.bufWords (bufWords)
	) i_audSampleBuf (
		.clock (clock),
		.bufWr (bufWr),
		.rdIdx (rdIdx),
		.block (block)
	);

	audSampleClock #(
		.bufWords (bufWords)
	) i_audSampleClock (
		.clock   (clock),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.sampPos (sampPos)
	);

	audSampleDecode #(
		.bufWords (bufWords)
	) i_audSampleDecode (
		.clock      (clock),
		.arstN      (arstN),
		.ctrl       (ctrl),
		.sampPos    (sampPos),
		.block      (block),
		.auxPcmL    (auxPcmL),
		.auxPcmR    (auxPcmR),
		.timerNoise (timerNoise),
		.levelL     (levelL),
		.levelR     (levelR)
	);

	audPwmDac i_audPwmDac (
		.clock  (clock),
		.arstN  (arstN),
		.ctrl   (ctrl),
		.levelL (levelL),
		.levelR (levelR),
		.pwmOut (pwmOut)
	);

endmodule

// File: tbAudPcm.sv
//**********************************************************
// testbench for the PCM sound device, replays the vector file
// and checks bus responses and PWM density
//**********************************************************
`timescale 1ns/1ps

module tbAudPcm;

	localparam int bufWords = 1024;
	localparam logic [11:0] windowSel = 12'h009;

	logic          clock;
	logic          arstN;
	audPkg::busReq busIn;
	logic [31:0]   busOutData;
	audPkg::busResp busOK;
	logic [7:0]    auxPcmL;
	logic [7:0]    auxPcmR;
	logic          timerNoise;
	logic [1:0]    pwmOut;

	int          seed = 53954;
	int          tests = 0;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          cycleLimit = 64;
	bit          testFail;
	logic [31:0] fillWord = '0;
	logic [31:0] ctrlModel = '0;

	audPcmTop #(
		.bufWords (bufWords)
	) i_audPcmTop (
		.clock      (clock),
		.arstN      (arstN),
		.busIn      (busIn),
		.busOutData (busOutData),
		.busOK      (busOK),
		.auxPcmL    (auxPcmL),
		.auxPcmR    (auxPcmR),
		.timerNoise (timerNoise),
		.pwmOut     (pwmOut)
	);

	always #4 clock = ~clock;

	// limit grows with each command read from the vectors
	always @(posedge clock)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout: run passed %0d cycles before the vectors finished", cycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic markFail();
		errors++;
		testFail = 1'b1;
	endtask

	task automatic checkValue(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			markFail();
		end
	endtask

	task automatic argsCheck(input int got, input int want);
		assert (got == want)
		else
		begin
			$display("malformed vector line, %0d of %0d fields read", got, want);
			markFail();
		end
	endtask

	// expected pwm high count per 65536 cycles for a constant sample word
	function automatic int levelModel(input logic [31:0] word, input logic [31:0] ctl,
		input logic [7:0] aux);
		int e;
		int m;
		int ex;
		int s12;
		if (!ctl[3])
			return 65536;
		e = word[6:4];
		m = word[3:0];
		if (ctl[1])
			s12 = ctl[0] ? (word[15:4] ^ 12'h800) : word[15:4];
		else if (ctl[0])
		begin
			// segment base doubles per exponent, mantissa bits refill the low end
			ex = (e == 0) ? m : (((16 + m) << (e - 1)) | ((m << (e - 1)) >> 4));
			s12 = word[7] ? 2048 + ex : 2047 - ex;
		end
		else
			s12 = word[7:0] * 16;
		return (s12 * 16 + s12 / 256 + aux * 256) % 65536;
	endfunction

	// request in one cycle, response checked one and two cycles later
	task automatic busAccess(input logic [31:0] addr, input logic [31:0] data,
		input audPkg::busOpm opm);
		int expResp;
		expResp = (addr[27:16] == windowSel) ? audPkg::respOk : audPkg::respReady;
		@(posedge clock);
		busIn.addr <= addr;
		busIn.data <= data;
		busIn.opm  <= opm;
		@(posedge clock);
		busIn <= '0;
		@(negedge clock);
		checkValue("busOK", busOK, audPkg::respReady);
		@(negedge clock);
		checkValue("busOK", busOK, expResp);
		checkValue("busOutData", busOutData, 0);
		if ((opm == audPkg::opmStore32) && (expResp == audPkg::respOk) &&
			(addr[15:2] == 14'h3C00))
			ctrlModel = data;
	endtask

	task automatic outsideAccesses(input int count);
		logic [31:0] addr;
		for (int i = 0; i < count; i++)
		begin
			addr = $random(seed);
			if (addr[27:16] == windowSel)
				addr[16] = ~addr[16];
			busAccess(addr, $random(seed), addr[0] ? audPkg::opmLoad32 : audPkg::opmStore32);
		end
	endtask

	// back to back stores, bank in address bit 2
	task automatic fillBuffer(input logic [31:0] word);
		for (int i = 0; i < 2 * bufWords; i++)
		begin
			@(posedge clock);
			busIn.addr <= {16'h0009, 16'(i << 2)};
			busIn.data <= word;
			busIn.opm  <= audPkg::opmStore32;
		end
		@(posedge clock);
		busIn <= '0;
		fillWord = word;
	endtask

	task automatic densityCheck(input int expL, input int expR);
		int cntL;
		int cntR;
		cntL = 0;
		cntR = 0;
		repeat (8) @(posedge clock);
		repeat (65536)
		begin
			@(negedge clock);
			cntL += pwmOut[0];
			cntR += pwmOut[1];
		end
		checkValue("pwmOut[0] count", cntL, expL);
		checkValue("pwmOut[1] count", cntR, expR);
	endtask

	initial
	begin
		int          fd;
		int          rc;
		int          modelL;
		int          modelR;
		logic [63:0] cmd;
		logic [8*200-1:0] line;
		logic [31:0] a;
		logic [31:0] b;
		string       kind;

		clock = 1'b0;
		arstN = 1'b0;
		busIn = '0;
		auxPcmL = '0;
		auxPcmR = '0;
		timerNoise = 1'b0;
		repeat (4) @(posedge clock);
		arstN <= 1'b1;
		@(negedge clock);
		tests++;
		testFail = 1'b0;
		checkValue("pwmOut", pwmOut, 2'b11);
		checkValue("busOK", busOK, audPkg::respReady);
		checkValue("busOutData", busOutData, 0);
		$display("test %0d reset state %s", tests, testFail ? "failed" : "passed");

		fd = $fopen("audPcmVectors.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the vector file audPcmVectors.txt");
			errors++;
		end
		else
		begin
			while ($fscanf(fd, "%s", cmd) == 1)
			begin
				if (cmd == "#")
					rc = $fgets(line, fd);
				else
				begin
					tests++;
					testFail = 1'b0;
					case (cmd)
						"L":
						begin
							rc = $fscanf(fd, "%h", a);
							argsCheck(rc, 1);
							cycleLimit += 8;
							busAccess(a, 32'h0, audPkg::opmLoad32);
							kind = "load";
						end
						"S":
						begin
							rc = $fscanf(fd, "%h %h", a, b);
							argsCheck(rc, 2);
							cycleLimit += 8;
							busAccess(a, b, audPkg::opmStore32);
							kind = "store";
						end
						"N":
						begin
							rc = $fscanf(fd, "%h", a);
							argsCheck(rc, 1);
							cycleLimit += 8 * a + 8;
							outsideAccesses(a);
							kind = "outside window";
						end
						"A":
						begin
							rc = $fscanf(fd, "%h %h", a, b);
							argsCheck(rc, 2);
							cycleLimit += 4;
							@(posedge clock);
							auxPcmL <= a[7:0];
							auxPcmR <= b[7:0];
							// new aux levels visible to the model
							@(negedge clock);
							kind = "aux";
						end
						"F":
						begin
							rc = $fscanf(fd, "%h", a);
							argsCheck(rc, 1);
							cycleLimit += 2 * bufWords + 8;
							fillBuffer(a);
							kind = "fill";
						end
						"D":
						begin
							rc = $fscanf(fd, "%h %h", a, b);
							argsCheck(rc, 2);
							cycleLimit += 65536 + 16;
							modelL = levelModel(fillWord, ctrlModel, auxPcmL);
							modelR = levelModel(fillWord, ctrlModel, auxPcmR);
							assert ((modelL == a) && (modelR == b))
							else
							begin
								$display("vector expects %0h %0h but the level rule gives %0h %0h",
									a, b, modelL, modelR);
								markFail();
							end
							densityCheck(a, b);
							kind = "density";
						end
						default:
						begin
							$display("unknown vector command %s", cmd);
							markFail();
							kind = "unknown";
						end
					endcase
					$display("test %0d %s %s", tests, kind, testFail ? "failed" : "passed");
				end
			end
			$fclose(fd);
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: audPcmVectors.txt
# cmd: L addr | S addr data | N count | A auxL auxR | F word | D expL expR
# fields in hex, D gives pwm high counts per channel over 65536 cycles
L 00090000
S 00094000 12345678
N 10
S 0009F000 00000008 F 40404040 D 4004 4004
S 0009F000 00000058 F C3C3C3C3 D C30C C30C
S 0009F000 000000F8 F 17171717 D 1701 1701
S 0009F000 00000009 F 05050505 D 7FA7 7FA7
F 9A9A9A9A D 81A8 81A8
F 2C2C2C2C D 7C67 7C67
F B7B7B7B7 D 85D8 85D8
F 43434343 D 7667 7667
F DEDEDEDE D 9EE9 9EE9
F 61616161 D 5DD5 5DD5
F FFFFFFFF D FFCF FFCF
S 0009F000 0000000A F 8E3A8E3A D 8E38 8E38
S 0009F000 0000001B D 0E30 0E30
A 12 F8 D 2030 0630
S 0009F000 00000003 D 10000 10000

// File: filelist.f
audPkg.sv
audBusRegs.sv
audSampleBuf.sv
audSampleClock.sv
audSampleDecode.sv
audPwmDac.sv
audPcmTop.sv
tbAudPcm.sv
